// File: common/albuf_cfg.svh
/*
  Build-time sizes of the instruction alignment buffer.
  The datapath slices fixed 16-bit halfwords, so ALBUF_XLEN must stay 32.
  ALBUF_DEPTH also limits buffered words plus outstanding requests.
*/
`ifndef ALBUF_CFG_SVH
`define ALBUF_CFG_SVH

// Word FIFO entries
`define ALBUF_DEPTH 3
// FIFO pointer and occupancy widths
`define ALBUF_PTR_W ($clog2(`ALBUF_DEPTH))
`define ALBUF_CNT_W (`ALBUF_PTR_W + 1)
// Most requests that may await a response
`define ALBUF_MAX_OUTSTANDING 2
// Address and fetch word width
`define ALBUF_XLEN 32

`endif

// File: common/albuf_pkg.sv
/*
  Types shared by the fetch controller, word FIFO and aligner.
  The fetch word carries one response word plus its bus error flag.
*/
`include "albuf_cfg.svh"

package albuf_pkg;

  // One response word as stored in the FIFO
  typedef struct packed {
    logic                   err;
    logic [`ALBUF_XLEN-1:0] data;
  } fetch_word_t;

  // Length class of the instruction at the current halfword
  // Low two bits of 2'b11 mark a 32-bit encoding
  typedef enum logic {
    INSTR_C16 = 1'b0,
    INSTR_32  = 1'b1
  } instr_len_e;

endpackage

// File: hw/fetch_ctrl/fetch_ctrl.sv
/*
  Issues word fetch requests and forwards responses into the word FIFO.
  Idle after reset until the first branch. Memory must return exactly one
  in-order response per accepted request, at least one cycle later.
*/
`include "albuf_cfg.svh"

module fetch_ctrl import albuf_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  // Branch
  input  logic                    branch_i,
  input  logic [`ALBUF_XLEN-1:0]  branch_addr_i,
  // Fetch request port
  output logic                    fetch_valid_o,
  input  logic                    fetch_ready_i,
  output logic [`ALBUF_XLEN-1:0]  fetch_addr_o,
  // Response port
  input  logic                    resp_valid_i,
  input  fetch_word_t             resp_word_i,
  // Push into the word FIFO
  output logic                    push_o,
  output fetch_word_t             push_word_o,
  input  logic [`ALBUF_CNT_W-1:0] fifo_count_i
);

  localparam int unsigned CNT_W = `ALBUF_CNT_W;
  localparam int unsigned XLEN  = `ALBUF_XLEN;

  logic             started_q;
  logic [XLEN-1:0]  addr_q;
  logic [CNT_W-1:0] outst_q;
  logic [CNT_W-1:0] outst_d;
  logic [CNT_W-1:0] flush_q;
  logic [CNT_W-1:0] flush_d;
  logic [CNT_W:0]   occupancy;
  logic             req_accept;
  logic             flushing;

  //////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////

  // Words held plus words still on their way
  assign occupancy = {1'b0, fifo_count_i} + {1'b0, outst_q};

  // Request only while every pending response is sure to find a free entry
  assign fetch_valid_o = started_q && !branch_i
                      && (outst_q < `ALBUF_MAX_OUTSTANDING)
                      && (occupancy < `ALBUF_DEPTH);
  assign fetch_addr_o  = addr_q;
  assign req_accept    = fetch_valid_o && fetch_ready_i;

  // Outstanding count tracks accepted requests against responses
  always_comb begin
    outst_d = outst_q;
    if (req_accept && !resp_valid_i) begin
      outst_d = outst_q + CNT_W'(1);
    end else if (!req_accept && resp_valid_i) begin
      outst_d = outst_q - CNT_W'(1);
    end
  end

  //////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////

  // Responses already requested before a branch belong to the old stream
  assign flushing = (flush_q != '0);

  always_comb begin
    flush_d = flush_q;
    if (branch_i) begin
      // A response in the branch cycle is dropped here and not counted
      flush_d = resp_valid_i ? (outst_q - CNT_W'(1)) : outst_q;
    end else if (resp_valid_i && flushing) begin
      flush_d = flush_q - CNT_W'(1);
    end
  end

  assign push_o      = resp_valid_i && !flushing && !branch_i;
  assign push_word_o = resp_word_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      started_q <= 1'b0;
      addr_q    <= '0;
      outst_q   <= '0;
      flush_q   <= '0;
    end else begin
      outst_q <= outst_d;
      flush_q <= flush_d;
      if (branch_i) begin
        // First branch doubles as the boot branch
        started_q <= 1'b1;
        addr_q    <= {branch_addr_i[XLEN-1:2], 2'b00};
      end else if (req_accept) begin
        addr_q <= addr_q + XLEN'(4);
      end
    end
  end

endmodule

// File: hw/word_fifo/word_fifo.sv
/*
  Circular buffer of fetched words with head and following entry visible.
  Pushing into a full buffer is not guarded. The request policy prevents it.
*/
`include "albuf_cfg.svh"

module word_fifo import albuf_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    clear_i,
  // Write side
  input  logic                    push_i,
  input  fetch_word_t             push_word_i,
  // Read side
  input  logic                    pop_i,
  output logic                    head_valid_o,
  output fetch_word_t             head_word_o,
  output logic                    next_valid_o,
  output fetch_word_t             next_word_o,
  output logic [`ALBUF_CNT_W-1:0] count_o
);

  localparam int unsigned DEPTH = `ALBUF_DEPTH;
  localparam int unsigned PTR_W = `ALBUF_PTR_W;
  localparam int unsigned CNT_W = `ALBUF_CNT_W;

  fetch_word_t      mem_q [DEPTH];
  logic [DEPTH-1:0] valid_q;
  logic [PTR_W-1:0] wptr_q;
  logic [PTR_W-1:0] rptr_q;
  logic [PTR_W-1:0] rptr_nxt;
  logic [CNT_W-1:0] count_q;

  // Pointer step with wrap at the last entry
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign rptr_nxt = ptr_inc(rptr_q);

  // Head and the entry behind it
  assign head_valid_o = valid_q[rptr_q];
  assign head_word_o  = mem_q[rptr_q];
  assign next_valid_o = valid_q[rptr_nxt];
  assign next_word_o  = mem_q[rptr_nxt];
  assign count_o      = count_q;

  //////////////////////////////////////////////////
  // Control state
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else if (clear_i) begin
      // Branch drops every buffered word
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_i) begin
        valid_q[wptr_q] <= 1'b1;
        wptr_q          <= ptr_inc(wptr_q);
      end
      // Pop and push never hit the same entry since a full buffer takes no push
      if (pop_i) begin
        valid_q[rptr_q] <= 1'b0;
        rptr_q          <= rptr_nxt;
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + CNT_W'(1);
      end else if (!push_i && pop_i) begin
        count_q <= count_q - CNT_W'(1);
      end
    end
  end

  // Word storage
  always_ff @(posedge clk) begin
    if (push_i && !clear_i) begin
      mem_q[wptr_q] <= push_word_i;
    end
  end

endmodule

// File: hw/instr_aligner/instr_aligner.sv
/*
  Assembles 16-bit and 32-bit instructions from the FIFO head and next word.
  Halfword slicing assumes 32-bit words. Bit 0 of the branch target is ignored.
  A compressed instruction is returned in bits 15:0 only.
*/
`include "albuf_cfg.svh"

module instr_aligner import albuf_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  // Branch
  input  logic                   branch_i,
  input  logic [`ALBUF_XLEN-1:0] branch_addr_i,
  // FIFO read side
  input  logic                   head_valid_i,
  input  fetch_word_t            head_word_i,
  input  logic                   next_valid_i,
  input  fetch_word_t            next_word_i,
  output logic                   pop_o,
  // Instruction port
  output logic                   instr_valid_o,
  input  logic                   instr_ready_i,
  output logic [`ALBUF_XLEN-1:0] instr_o,
  output logic [`ALBUF_XLEN-1:0] instr_addr_o,
  output logic                   instr_err_o
);

  localparam int unsigned XLEN = `ALBUF_XLEN;

  logic [XLEN-1:0] addr_q;
  logic [15:0]     cur_half;
  instr_len_e      instr_len;
  logic            avail;
  logic            uses_head;
  logic [XLEN-1:0] step;
  logic            emit;

  //////////////////////////////////////////////////
  // Decode at the current halfword
  //////////////////////////////////////////////////

  // Address bit 1 picks the halfword within the head word
  assign cur_half  = addr_q[1] ? head_word_i.data[31:16] : head_word_i.data[15:0];
  assign instr_len = (cur_half[1:0] != 2'b11) ? INSTR_C16 : INSTR_32;

  always_comb begin
    instr_o     = head_word_i.data;
    instr_err_o = head_word_i.err;
    avail       = head_valid_i;
    uses_head   = 1'b1;
    step        = XLEN'(4);
    case ({addr_q[1], instr_len})
      {1'b0, INSTR_C16}: begin
        // Low half only, upper half stays in the head
        uses_head = 1'b0;
        step      = XLEN'(2);
      end
      {1'b0, INSTR_32}: begin
        // Whole head word, defaults apply
      end
      {1'b1, INSTR_C16}: begin
        instr_o = {16'h0000, head_word_i.data[31:16]};
        step    = XLEN'(2);
      end
      default: begin
        // Split across words
        instr_o     = {next_word_i.data[15:0], head_word_i.data[31:16]};
        instr_err_o = head_word_i.err | next_word_i.err;
        avail       = head_valid_i && next_valid_i;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Handshake and program counter
  //////////////////////////////////////////////////

  // Held off in the branch cycle so nothing of the old stream escapes
  assign instr_valid_o = avail && !branch_i;
  assign instr_addr_o  = addr_q;
  assign emit          = instr_valid_o && instr_ready_i;

  // Pop once the head word is fully consumed
  assign pop_o = emit && uses_head;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (branch_i) begin
      addr_q <= {branch_addr_i[XLEN-1:1], 1'b0};
    end else if (emit) begin
      addr_q <= addr_q + step;
    end
  end

endmodule

// File: hw/alignment_buffer.sv
/*
  Top of the instruction alignment buffer.
  Nothing is fetched until the first branch. The response port has no ready
  since the request policy always leaves room for every response.
*/
`include "albuf_cfg.svh"

module alignment_buffer import albuf_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  // Branch
  input  logic                   branch_i,
  input  logic [`ALBUF_XLEN-1:0] branch_addr_i,
  // Fetch request port
  output logic                   fetch_valid_o,
  input  logic                   fetch_ready_i,
  output logic [`ALBUF_XLEN-1:0] fetch_addr_o,
  // Response port
  input  logic                   resp_valid_i,
  input  logic [`ALBUF_XLEN-1:0] resp_rdata_i,
  input  logic                   resp_err_i,
  // Instruction port
  output logic                   instr_valid_o,
  input  logic                   instr_ready_i,
  output logic [`ALBUF_XLEN-1:0] instr_o,
  output logic [`ALBUF_XLEN-1:0] instr_addr_o,
  output logic                   instr_err_o
);

  fetch_word_t             resp_word;
  logic                    push;
  fetch_word_t             push_word;
  logic                    pop;
  logic                    head_valid;
  fetch_word_t             head_word;
  logic                    next_valid;
  fetch_word_t             next_word;
  logic [`ALBUF_CNT_W-1:0] fifo_count;

  // Response word with its error flag
  assign resp_word = '{err: resp_err_i, data: resp_rdata_i};

  // Producer
  fetch_ctrl u_fetch_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .fetch_valid_o (fetch_valid_o),
    .fetch_ready_i (fetch_ready_i),
    .fetch_addr_o  (fetch_addr_o),
    .resp_valid_i  (resp_valid_i),
    .resp_word_i   (resp_word),
    .push_o        (push),
    .push_word_o   (push_word),
    .fifo_count_i  (fifo_count)
  );

  // Buffer cleared by the branch
  word_fifo u_word_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear_i      (branch_i),
    .push_i       (push),
    .push_word_i  (push_word),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_word_o  (head_word),
    .next_valid_o (next_valid),
    .next_word_o  (next_word),
    .count_o      (fifo_count)
  );

  // Consumer
  instr_aligner u_instr_aligner (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .head_valid_i  (head_valid),
    .head_word_i   (head_word),
    .next_valid_i  (next_valid),
    .next_word_i   (next_word),
    .pop_o         (pop),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_o       (instr_o),
    .instr_addr_o  (instr_addr_o),
    .instr_err_o   (instr_err_o)
  );

endmodule

// File: testbench/tb_alignment_buffer.sv
/*
  Random stream test of the alignment buffer against a halfword memory model.
  The memory wraps at 2 KB, and the expected stream wraps the same way.
  Responses return in order after 1 to 3 cycles.
*/
`include "albuf_cfg.svh"

module tb_alignment_buffer import albuf_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_INSTR = 3000;
  localparam int MEM_HW  = 1024;

  logic        clk;
  logic        rst_n;
  logic        branch_i;
  logic [31:0] branch_addr_i;
  logic        fetch_valid_o;
  logic        fetch_ready_i;
  logic [31:0] fetch_addr_o;
  logic        resp_valid_i;
  logic [31:0] resp_rdata_i;
  logic        resp_err_i;
  logic        instr_valid_o;
  logic        instr_ready_i;
  logic [31:0] instr_o;
  logic [31:0] instr_addr_o;
  logic        instr_err_o;

  // Memory image and per-word bus error flags
  logic [15:0] mem_h [MEM_HW];
  logic        err_w [MEM_HW/2];
  // Accepted requests awaiting their response
  logic [31:0] pend_addr [$];
  int          pend_due [$];

  logic [31:0] rng = 32'hbffb_0fd8;
  logic [31:0] exp_addr;
  logic [31:0] exp_fetch;
  logic [31:0] held_addr;
  logic [31:0] held_instr;
  logic        booted = 1'b0;
  logic        held = 1'b0;
  int          cyc = 0;
  int          outst = 0;
  int          n_xfer = 0;
  int          since_br = 0;
  int          n_split = 0;
  int          n_split_err2 = 0;
  int          n_branch = 0;
  int          n_mismatch = 0;
  int          n_other = 0;

  alignment_buffer u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    n_mismatch++;
    $display("Mismatch %s: expected %h actual %h at %0t", name, exp_v, act_v, $time);
  endtask

  task automatic report_failure(input string msg);
    n_other++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  // Expected instruction starting at a halfword address
  function automatic void ref_instr(input logic [31:0] addr, output logic [31:0] instr,
                                    output instr_len_e len, output logic [31:0] next_addr,
                                    output logic err);
    logic [15:0] lo;
    logic [15:0] hi;
    logic [31:0] a2;
    a2 = addr + 32'd2;
    lo = mem_h[addr[10:1]];
    hi = mem_h[a2[10:1]];
    if (lo[1:0] != 2'b11) begin
      len       = INSTR_C16;
      instr     = {16'h0000, lo};
      next_addr = a2;
      err       = err_w[addr[10:2]];
    end else begin
      // Second half may sit in the following word
      len       = INSTR_32;
      instr     = {hi, lo};
      next_addr = addr + 32'd4;
      err       = err_w[addr[10:2]] | err_w[a2[10:2]];
    end
  endfunction

  // Random ready throttling and the next due response
  task automatic drive_handshakes();
    logic [31:0] r;
    logic [31:0] a;
    r = next_rand();
    fetch_ready_i = (r[1:0] != 2'b00);
    instr_ready_i = (r[3:2] != 2'b00);
    resp_valid_i  = 1'b0;
    if (pend_addr.size() != 0 && pend_due[0] <= cyc) begin
      a = pend_addr.pop_front();
      void'(pend_due.pop_front());
      resp_valid_i = 1'b1;
      resp_rdata_i = {mem_h[{a[10:2], 1'b1}], mem_h[{a[10:2], 1'b0}]};
      resp_err_i   = err_w[a[10:2]];
    end
  endtask

  //////////////////////////////////////////////////
  // Monitor and comparison
  //////////////////////////////////////////////////

  always @(posedge clk) begin : monitor
    logic [31:0] e_instr;
    logic [31:0] e_next;
    logic        e_err;
    instr_len_e  e_len;
    if (rst_n) begin
      cyc++;
      // Nothing may move before the boot branch
      if (!booted) begin
        assert (!fetch_valid_o && !instr_valid_o)
        else report_failure("valid output raised before the first branch");
      end
      // Request side and outstanding limit
      if (fetch_valid_o && fetch_ready_i) begin
        assert (fetch_addr_o == exp_fetch)
        else report_mismatch("fetch_addr", exp_fetch, fetch_addr_o);
        exp_fetch = exp_fetch + 32'd4;
        pend_addr.push_back(fetch_addr_o);
        pend_due.push_back(cyc + int'(next_rand() % 3));
        outst++;
      end
      // A response in this cycle does not free room for a request in this cycle
      assert (outst <= `ALBUF_MAX_OUTSTANDING)
      else report_failure("more requests outstanding than allowed");
      if (resp_valid_i) outst--;
      // Stalled instruction must hold
      if (held && !branch_i) begin
        assert (instr_valid_o) else report_failure("instruction valid dropped while stalled");
        assert (instr_addr_o == held_addr)
        else report_mismatch("hold_addr", held_addr, instr_addr_o);
        assert (instr_o == held_instr) else report_mismatch("hold_instr", held_instr, instr_o);
      end
      held       = instr_valid_o && !instr_ready_i && !branch_i;
      held_addr  = instr_addr_o;
      held_instr = instr_o;
      // Transfer against the reference
      if (instr_valid_o && instr_ready_i) begin
        ref_instr(exp_addr, e_instr, e_len, e_next, e_err);
        assert (instr_addr_o == exp_addr)
        else report_mismatch("stream_addr", exp_addr, instr_addr_o);
        if (e_len == INSTR_C16) begin
          assert (instr_o[15:0] == e_instr[15:0])
          else report_mismatch("stream_c16", e_instr, instr_o);
        end else begin
          assert (instr_o == e_instr) else report_mismatch("stream_i32", e_instr, instr_o);
        end
        assert (instr_err_o == e_err)
        else report_mismatch("stream_err", 32'(e_err), 32'(instr_err_o));
        if (e_len == INSTR_32 && exp_addr[1]) begin
          n_split++;
          // Error carried only by the second word of a split instruction
          if (e_err && !err_w[exp_addr[10:2]]) n_split_err2++;
        end
        exp_addr = e_next;
        n_xfer++;
        since_br++;
      end
      // Branch restarts both expected streams
      if (branch_i) begin
        assert (!instr_valid_o && !fetch_valid_o)
        else report_failure("valid output raised in a branch cycle");
        booted    = 1'b1;
        exp_addr  = {branch_addr_i[31:1], 1'b0};
        exp_fetch = {branch_addr_i[31:2], 2'b00};
        since_br  = 0;
        n_branch++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin : main
    logic [31:0] r;
    int          quota;
    int          i;
    rst_n = 1'b0;
    branch_i = 1'b0;
    branch_addr_i = '0;
    fetch_ready_i = 1'b0;
    resp_valid_i = 1'b0;
    resp_rdata_i = '0;
    resp_err_i = 1'b0;
    instr_ready_i = 1'b0;
    // Roughly half of the halfwords open a 32-bit encoding
    for (i = 0; i < MEM_HW; i++) begin
      r = next_rand();
      mem_h[i] = r[15:0];
      if (r[16]) mem_h[i][1:0] = 2'b11;
      else if (r[1:0] == 2'b11) mem_h[i][1:0] = 2'b01;
      if (i % 2 == 0) err_w[i/2] = (r[22:20] == 3'b000);
    end
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    // Idle window before the boot branch
    for (i = 0; i < 10; i++) begin
      @(negedge clk);
      drive_handshakes();
    end
    @(negedge clk);
    drive_handshakes();
    branch_addr_i = 32'h0000_0100;
    branch_i = 1'b1;
    quota = 200;
    while (n_xfer < N_INSTR) begin
      @(negedge clk);
      branch_i = 1'b0;
      drive_handshakes();
      r = next_rand();
      // Prefer branching while responses are still in flight
      if (since_br >= quota && (pend_addr.size() != 0 || r[31])) begin
        branch_addr_i = {20'h0, r[11:0]};
        branch_i = 1'b1;
        quota = 10 + int'(r[20:15]);
      end
    end
    @(negedge clk);
    branch_i = 1'b0;
    assert (n_split != 0) else report_failure("no split instruction was transferred");
    assert (n_split_err2 != 0)
    else report_failure("no split instruction had an error on its second word only");
    $display("transfers=%0d splits=%0d split_err2=%0d branches=%0d mismatches=%0d other_errors=%0d",
             n_xfer, n_split, n_split_err2, n_branch, n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Budget of 40 cycles per instruction
  initial begin : watchdog
    repeat (N_INSTR * 40) @(posedge clk);
    $display("Timeout: only %0d of %0d instructions transferred", n_xfer, N_INSTR);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: flist.f
+incdir+common
common/albuf_pkg.sv
hw/fetch_ctrl/fetch_ctrl.sv
hw/word_fifo/word_fifo.sv
hw/instr_aligner/instr_aligner.sv
hw/alignment_buffer.sv
testbench/tb_alignment_buffer.sv
